// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_rv_core
FLIST     ?= flist.f
SEED_ARGS ?=
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell cat $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN) $(SEED_ARGS))"; echo "$$out"; \
	echo "$$out" | grep -q "Done: no errors"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== alu.sv ====
/*
 * Integer ALU. The operation comes from alu_op with sub and arithmetic
 * selecting the variant. Flags always reflect a - b, so one compare
 * resolves any branch.
 */
`default_nettype none

module alu
  import rv_core_pkg::*;
(
  input  wire [data_size-1:0]  a,
  input  wire [data_size-1:0]  b,
  input  wire alu_op_t         alu_op,
  input  wire                  sub,
  input  wire                  arithmetic,
  output logic [data_size-1:0] y,
  output logic                 zero,
  output logic                 negative,
  output logic                 carry_out,
  output logic                 overflow
);

  logic [data_size-1:0] diff;
  logic [data_size-1:0] sum;
  logic [4:0]           shamt;
  logic                 less_signed;
  logic                 less_unsigned;

  // Subtraction path as a + ~b + 1, carry out is the no-borrow bit
  assign {carry_out, diff} = {1'b0, a} + {1'b0, ~b} + {{data_size{1'b0}}, 1'b1};
  assign sum   = a + b;
  assign shamt = b[4:0];

  assign zero     = (diff == '0);
  assign negative = diff[data_size-1];
  assign overflow = (a[data_size-1] != b[data_size-1]) &&
                    (diff[data_size-1] != a[data_size-1]);

  assign less_signed   = negative ^ overflow;
  assign less_unsigned = ~carry_out;

  always_comb begin
    case (alu_op)
      alu_add:  y = sub ? diff : sum;
      alu_sll:  y = a << shamt;
      alu_slt:  y = {{(data_size-1){1'b0}}, less_signed};
      alu_sltu: y = {{(data_size-1){1'b0}}, less_unsigned};
      alu_xor:  y = a ^ b;
      alu_sr: begin
        if (arithmetic) begin
          y = $signed(a) >>> shamt;
        end else begin
          y = a >> shamt;
        end
      end
      alu_or:   y = a | b;
      alu_and:  y = a & b;
      default:  y = sum;
    endcase
  end

endmodule

`default_nettype wire

// ==== control_unit.sv ====
/*
 * Multicycle sequencer. Mux selects follow the opcode in IR, enables
 * follow the FSM state. ALU-class, jumps and branches take 3 cycles,
 * stores 4 and loads 5.
 */
`default_nettype none

module control_unit
  import rv_isa_pkg::*;
  import rv_core_pkg::*;
(
  input  wire        clock,
  input  wire        reset,
  input  wire [6:0]  opcode,
  input  wire [2:0]  funct3,
  input  wire [6:0]  funct7,
  input  wire        zero,
  input  wire        negative,
  input  wire        carry_out,
  input  wire        overflow,
  output logic       alua_src,
  output logic       alub_src,
  output alu_op_t    alu_op,
  output logic       sub,
  output logic       arithmetic,
  output logic       alupc_src,
  output logic       pc_src,
  output logic       pc_en,
  output logic       ir_en,
  output wb_sel_t    wr_reg_src,
  output logic       wr_reg_en,
  output logic       mem_addr_src,
  output logic       mem_wr_en
);

  core_state_t state;
  core_state_t next_state;
  logic        is_load;
  logic        is_store;
  logic        is_alu;
  logic        writes_rd;
  logic        take_branch;

  assign is_load  = (opcode == op_load);
  assign is_store = (opcode == op_store);
  assign is_alu   = (opcode == op_reg) || (opcode == op_imm);
  assign writes_rd = is_alu || opcode == op_lui || opcode == op_auipc ||
                     opcode == op_jal || opcode == op_jalr;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= st_fetch;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    case (state)
      st_fetch:   next_state = st_decode;
      st_decode:  next_state = st_execute;
      st_execute: next_state = (is_load || is_store) ? st_memory : st_fetch;
      st_memory:  next_state = is_load ? st_writeback : st_fetch;
      default:    next_state = st_fetch;
    endcase
  end

  // Branch condition from the rs1 - rs2 flags
  always_comb begin
    case (funct3)
      f3_beq:  take_branch = zero;
      f3_bne:  take_branch = ~zero;
      f3_blt:  take_branch = negative ^ overflow;
      f3_bge:  take_branch = ~(negative ^ overflow);
      f3_bltu: take_branch = ~carry_out;
      f3_bgeu: take_branch = carry_out;
      default: take_branch = 1'b0;
    endcase
  end

  // Selects, valid in every state
  always_comb begin
    alua_src   = (opcode == op_auipc);
    alub_src   = (opcode != op_reg) && (opcode != op_branch);
    alupc_src  = (opcode == op_jalr);
    alu_op     = is_alu ? alu_op_t'(funct3) : alu_add;
    sub        = (opcode == op_branch) ||
                 (opcode == op_reg && funct3 == f3_add_sub && funct7[5]);
    arithmetic = is_alu && funct3 == f3_srl_sra && funct7[5];
    pc_src     = (opcode == op_jal) || (opcode == op_jalr) ||
                 (opcode == op_branch && take_branch);
    case (opcode)
      op_lui:          wr_reg_src = wb_imm;
      op_jal, op_jalr: wr_reg_src = wb_pc4;
      op_load:         wr_reg_src = wb_mem;
      default:         wr_reg_src = wb_alu;
    endcase
  end

  // Enables per state
  always_comb begin
    pc_en        = 1'b0;
    ir_en        = 1'b0;
    wr_reg_en    = 1'b0;
    mem_addr_src = 1'b0;
    mem_wr_en    = 1'b0;
    case (state)
      st_fetch: ir_en = 1'b1;
      st_execute: begin
        // Loads and stores only form the address here
        if (!is_load && !is_store) begin
          pc_en     = 1'b1;
          wr_reg_en = writes_rd;
        end
      end
      st_memory: begin
        mem_addr_src = 1'b1;
        if (is_store) begin
          mem_wr_en = 1'b1;
          pc_en     = 1'b1;
        end
      end
      st_writeback: begin
        mem_addr_src = 1'b1;
        wr_reg_en    = 1'b1;
        pc_en        = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// ==== dataflow.sv ====
/*
 * Datapath of the multicycle core: PC and IR registers, register file,
 * ALU operand muxes, PC adders, write-back mux and memory address mux.
 * All selects and enables come from the control unit.
 */
`default_nettype none

module dataflow
  import rv_core_pkg::*;
(
  input  wire                  clock,
  input  wire                  reset,
  input  wire [data_size-1:0]  rd_data,
  output logic [data_size-1:0] wr_data,
  output logic [data_size-1:0] mem_addr,
  input  wire                  alua_src,
  input  wire                  alub_src,
  input  wire alu_op_t         alu_op,
  input  wire                  sub,
  input  wire                  arithmetic,
  input  wire                  alupc_src,
  input  wire                  pc_src,
  input  wire                  pc_en,
  input  wire                  ir_en,
  input  wire wb_sel_t         wr_reg_src,
  input  wire                  wr_reg_en,
  input  wire                  mem_addr_src,
  output logic [6:0]           opcode,
  output logic [2:0]           funct3,
  output logic [6:0]           funct7,
  output logic                 zero,
  output logic                 negative,
  output logic                 carry_out,
  output logic                 overflow
);

  logic [data_size-1:0] pc;
  logic [data_size-1:0] ir;
  logic [data_size-1:0] rs1;
  logic [data_size-1:0] rs2;
  logic [data_size-1:0] immediate;
  logic [data_size-1:0] alu_a;
  logic [data_size-1:0] alu_b;
  logic [data_size-1:0] alu_y;
  logic [data_size-1:0] pc_plus_4;
  logic [data_size-1:0] target_sum;
  logic [data_size-1:0] rd_value;

  always_ff @(posedge clock) begin
    if (reset) begin
      pc <= '0;
      ir <= '0;
    end else begin
      if (pc_en) begin
        pc <= pc_src ? {target_sum[data_size-1:1], 1'b0} : pc_plus_4;
      end
      if (ir_en) begin
        ir <= rd_data;
      end
    end
  end

  register_file u_regs (
    .clock         (clock),
    .reset         (reset),
    .write_enable  (wr_reg_en),
    .read_address1 (ir[19:15]),
    .read_address2 (ir[24:20]),
    .write_address (ir[11:7]),
    .write_data    (rd_value),
    .read_data1    (rs1),
    .read_data2    (rs2)
  );

  immediate_extender u_imm (
    .instruction (ir),
    .immediate   (immediate)
  );

  assign alu_a = alua_src ? pc : rs1;
  assign alu_b = alub_src ? immediate : rs2;

  alu u_alu (
    .a          (alu_a),
    .b          (alu_b),
    .alu_op     (alu_op),
    .sub        (sub),
    .arithmetic (arithmetic),
    .y          (alu_y),
    .zero       (zero),
    .negative   (negative),
    .carry_out  (carry_out),
    .overflow   (overflow)
  );

  assign pc_plus_4 = pc + data_size'(4);
  // Base is rs1 for JALR, bit 0 of the sum is cleared on PC load
  assign target_sum = (alupc_src ? rs1 : pc) + immediate;

  always_comb begin
    case (wr_reg_src)
      wb_alu:  rd_value = alu_y;
      wb_mem:  rd_value = rd_data;
      wb_pc4:  rd_value = pc_plus_4;
      wb_imm:  rd_value = immediate;
      default: rd_value = alu_y;
    endcase
  end

  assign mem_addr = mem_addr_src ? alu_y : pc;
  assign wr_data  = rs2;

  assign opcode = ir[6:0];
  assign funct3 = ir[14:12];
  assign funct7 = ir[31:25];

endmodule

`default_nettype wire

// ==== flist.f ====
rv_isa_pkg.sv
rv_core_pkg.sv
register_file.sv
alu.sv
immediate_extender.sv
dataflow.sv
control_unit.sv
rv_core.sv
tb_rv_core.sv

// ==== immediate_extender.sv ====
/*
 * Sign-extended immediate for the I, S, B, U and J formats. The format
 * follows from the opcode; anything unlisted is treated as I-type.
 */
`default_nettype none

module immediate_extender
  import rv_isa_pkg::*;
  import rv_core_pkg::*;
(
  input  wire [ilen-1:0]       instruction,
  output logic [data_size-1:0] immediate
);

  logic [6:0] opcode;
  logic       sign;

  assign opcode = instruction[6:0];
  assign sign   = instruction[31];

  always_comb begin
    case (opcode)
      op_store:
        immediate = {{(data_size-12){sign}}, instruction[31:25], instruction[11:7]};
      op_branch:
        immediate = {{(data_size-12){sign}}, instruction[7], instruction[30:25],
                     instruction[11:8], 1'b0};
      op_lui, op_auipc:
        immediate = {{(data_size-32){sign}}, instruction[31:12], 12'b0};
      op_jal:
        immediate = {{(data_size-20){sign}}, instruction[19:12], instruction[20],
                     instruction[30:21], 1'b0};
      default:
        immediate = {{(data_size-12){sign}}, instruction[31:20]};
    endcase
  end

endmodule

`default_nettype wire

// ==== register_file.sv ====
/*
 * Integer register file, 32 entries. Two asynchronous read ports and
 * one write port on the clock edge. Register x0 always reads as zero.
 */
`default_nettype none

module register_file
  import rv_core_pkg::*;
(
  input  wire                     clock,
  input  wire                     reset,
  input  wire                     write_enable,
  input  wire [reg_addr_bits-1:0] read_address1,
  input  wire [reg_addr_bits-1:0] read_address2,
  input  wire [reg_addr_bits-1:0] write_address,
  input  wire [data_size-1:0]     write_data,
  output logic [data_size-1:0]    read_data1,
  output logic [data_size-1:0]    read_data2
);

  logic [data_size-1:0] regs [2**reg_addr_bits];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < 2**reg_addr_bits; i++) begin
        regs[i] <= '0;
      end
    end else if (write_enable && write_address != '0) begin
      // Writes to x0 are dropped
      regs[write_address] <= write_data;
    end
  end

  assign read_data1 = (read_address1 == '0) ? '0 : regs[read_address1];
  assign read_data2 = (read_address2 == '0) ? '0 : regs[read_address2];

endmodule

`default_nettype wire

// ==== rv_core.sv ====
/*
 * Multicycle RV32I core. Joins datapath and control unit behind one
 * memory port with combinational read and clocked word write.
 */
`default_nettype none

module rv_core
  import rv_core_pkg::*;
(
  input  wire                  clock,
  input  wire                  reset,
  input  wire [data_size-1:0]  rd_data,
  output logic [data_size-1:0] mem_addr,
  output logic [data_size-1:0] wr_data,
  output logic                 mem_wr_en
);

  logic       alua_src;
  logic       alub_src;
  alu_op_t    alu_op;
  logic       sub;
  logic       arithmetic;
  logic       alupc_src;
  logic       pc_src;
  logic       pc_en;
  logic       ir_en;
  wb_sel_t    wr_reg_src;
  logic       wr_reg_en;
  logic       mem_addr_src;
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       zero;
  logic       negative;
  logic       carry_out;
  logic       overflow;

  dataflow u_dataflow (
    .clock        (clock),
    .reset        (reset),
    .rd_data      (rd_data),
    .wr_data      (wr_data),
    .mem_addr     (mem_addr),
    .alua_src     (alua_src),
    .alub_src     (alub_src),
    .alu_op       (alu_op),
    .sub          (sub),
    .arithmetic   (arithmetic),
    .alupc_src    (alupc_src),
    .pc_src       (pc_src),
    .pc_en        (pc_en),
    .ir_en        (ir_en),
    .wr_reg_src   (wr_reg_src),
    .wr_reg_en    (wr_reg_en),
    .mem_addr_src (mem_addr_src),
    .opcode       (opcode),
    .funct3       (funct3),
    .funct7       (funct7),
    .zero         (zero),
    .negative     (negative),
    .carry_out    (carry_out),
    .overflow     (overflow)
  );

  control_unit u_control (
    .clock        (clock),
    .reset        (reset),
    .opcode       (opcode),
    .funct3       (funct3),
    .funct7       (funct7),
    .zero         (zero),
    .negative     (negative),
    .carry_out    (carry_out),
    .overflow     (overflow),
    .alua_src     (alua_src),
    .alub_src     (alub_src),
    .alu_op       (alu_op),
    .sub          (sub),
    .arithmetic   (arithmetic),
    .alupc_src    (alupc_src),
    .pc_src       (pc_src),
    .pc_en        (pc_en),
    .ir_en        (ir_en),
    .wr_reg_src   (wr_reg_src),
    .wr_reg_en    (wr_reg_en),
    .mem_addr_src (mem_addr_src),
    .mem_wr_en    (mem_wr_en)
  );

endmodule

`default_nettype wire

// ==== rv_core_pkg.sv ====
/*
 * Internal encodings of the multicycle core: data width, ALU selector,
 * write-back source and FSM states.
 */
`default_nettype none

package rv_core_pkg;

  localparam int data_size     = 32;
  localparam int reg_addr_bits = 5;

  // Same order as funct3, sub and arithmetic pick the variant
  typedef enum logic [2:0] {
    alu_add  = 3'b000,
    alu_sll  = 3'b001,
    alu_slt  = 3'b010,
    alu_sltu = 3'b011,
    alu_xor  = 3'b100,
    alu_sr   = 3'b101,
    alu_or   = 3'b110,
    alu_and  = 3'b111
  } alu_op_t;

  // Register write-back source
  typedef enum logic [1:0] {
    wb_alu = 2'b00,
    wb_mem = 2'b01,
    wb_pc4 = 2'b10,
    wb_imm = 2'b11
  } wb_sel_t;

  typedef enum logic [2:0] {
    st_fetch,
    st_decode,
    st_execute,
    st_memory,
    st_writeback
  } core_state_t;

endpackage

`default_nettype wire

// ==== rv_isa_pkg.sv ====
/*
 * RV32I instruction-set constants shared by the decoder, the immediate
 * extender and the testbench program generator.
 */
`default_nettype none

package rv_isa_pkg;

  // Instruction width
  localparam int ilen = 32;

  // Major opcodes
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_reg    = 7'b0110011;

  // ALU funct3 field
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_sltu    = 3'b011;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_srl_sra = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;

  // Branch funct3 field
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

endpackage

`default_nettype wire

// ==== tb_rv_core.sv ====
/*
 * Testbench for the multicycle RV32I core. Generates a random program,
 * runs it on an instruction-level model and checks every store the core
 * makes, including a final dump of all registers.
 */
`default_nettype none

module tb_rv_core
  import rv_isa_pkg::*;
  import rv_core_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int mem_words   = 1024;
  localparam int body_len    = 200;
  localparam int total_instr = body_len + 31 + 1;
  // Every instruction at load cost plus margin
  localparam int cycle_limit = 5 * total_instr + 100;
  localparam logic [31:0] halt_addr = 32'(4 * (body_len + 31));

  logic                 clock;
  logic                 reset = 1'b1;
  logic [data_size-1:0] rd_data;
  logic [data_size-1:0] mem_addr;
  logic [data_size-1:0] wr_data;
  logic                 mem_wr_en;

  logic [31:0] image [mem_words];
  logic [31:0] mem [mem_words];
  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];
  int          seed = 83124;
  int          errors = 0;
  int          write_errors = 0;
  int          wr_count = 0;
  int          cycles = 0;
  logic        prev_wr_en = 1'b0;

  rv_core u_dut (
    .clock     (clock),
    .reset     (reset),
    .rd_data   (rd_data),
    .mem_addr  (mem_addr),
    .wr_data   (wr_data),
    .mem_wr_en (mem_wr_en)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  // Word memory with combinational read and write on the rising edge
  assign rd_data = mem[mem_addr[11:2]];

  always @(posedge clock) begin
    if (!reset && mem_wr_en) begin
      mem[mem_addr[11:2]] <= wr_data;
    end
  end

  function automatic int pick(int n);
    logic [31:0] r;
    r = $random(seed);
    return int'({1'b0, r[30:0]}) % n;
  endfunction

  function automatic logic [31:0] r_type_word(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                              logic [2:0] f3, logic [4:0] rd, logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] i_type_word(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                              logic [4:0] rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] store_word(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], op_store};
  endfunction

  function automatic logic [31:0] branch_word(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                              logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
  endfunction

  function automatic logic [31:0] upper_word(logic [19:0] imm, logic [4:0] rd, logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] jump_word(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
  endfunction

  // Immediate decoding per RV32I format
  function automatic logic [31:0] i_imm(logic [31:0] ins);
    return {{20{ins[31]}}, ins[31:20]};
  endfunction

  function automatic logic [31:0] s_imm(logic [31:0] ins);
    return {{20{ins[31]}}, ins[31:25], ins[11:7]};
  endfunction

  function automatic logic [31:0] b_imm(logic [31:0] ins);
    return {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
  endfunction

  function automatic logic [31:0] u_imm(logic [31:0] ins);
    return {ins[31:12], 12'b0};
  endfunction

  function automatic logic [31:0] j_imm(logic [31:0] ins);
    return {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
  endfunction

  function automatic logic [31:0] alu_result(logic [2:0] f3, logic alt, logic [31:0] a,
                                             logic [31:0] b);
    case (f3)
      f3_add_sub: return alt ? a - b : a + b;
      f3_sll:     return a << b[4:0];
      f3_slt:     return {31'b0, $signed(a) < $signed(b)};
      f3_sltu:    return {31'b0, a < b};
      f3_xor:     return a ^ b;
      f3_srl_sra: begin
        if (alt) begin
          return $signed(a) >>> b[4:0];
        end
        return a >> b[4:0];
      end
      f3_or:      return a | b;
      default:    return a & b;
    endcase
  endfunction

  function automatic logic branch_taken(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
    case (f3)
      f3_beq:  return a == b;
      f3_bne:  return a != b;
      f3_blt:  return $signed(a) < $signed(b);
      f3_bge:  return $signed(a) >= $signed(b);
      f3_bltu: return a < b;
      default: return a >= b;
    endcase
  endfunction

  task automatic build_program();
    int         kind;
    int         k;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [2:0] f3;
    logic [6:0] f7;
    logic [11:0] imm12;
    for (int w = 0; w < mem_words; w++) begin
      image[w] = 32'h6b00_0000 ^ (32'(w) * 32'h0009_0d05);
    end
    for (int i = 0; i < body_len; i++) begin
      kind = pick(16);
      rd   = 5'(pick(32));
      rs1  = 5'(pick(32));
      rs2  = 5'(pick(32));
      f3   = 3'(pick(8));
      // Forward jump distance that never passes the first dump store
      k    = 1 + pick((body_len - i < 4) ? body_len - i : 4);
      case (kind)
        0, 1, 2, 3: begin
          f7 = ((f3 == f3_add_sub || f3 == f3_srl_sra) && pick(2) == 1) ? 7'h20 : 7'h00;
          image[i] = r_type_word(f7, rs2, rs1, f3, rd, op_reg);
        end
        4, 5, 6: begin
          if (f3 == f3_sll) begin
            imm12 = {7'h00, rs2};
          end else if (f3 == f3_srl_sra) begin
            imm12 = {(pick(2) == 1) ? 7'h20 : 7'h00, rs2};
          end else begin
            imm12 = 12'(pick(4096));
          end
          image[i] = i_type_word(imm12, rs1, f3, rd, op_imm);
        end
        7: image[i] = upper_word(20'(pick(1 << 20)), rd, op_lui);
        8: image[i] = upper_word(20'(pick(1 << 20)), rd, op_auipc);
        9: begin
          // Spread 0..5 onto the six branch codes
          f3 = 3'(pick(6));
          if (f3 > 3'd1) begin
            f3 = f3 + 3'd2;
          end
          image[i] = branch_word(13'(4 * k), rs2, rs1, f3);
        end
        10: image[i] = jump_word(21'(4 * k), rd);
        // Odd target checks that bit 0 is dropped
        11: image[i] = i_type_word(12'(4 * (i + k) + 1), 5'd0, 3'b000, rd, op_jalr);
        // Small data window so that loads often hit earlier stores
        12, 13: image[i] = i_type_word(12'(-2048 + 4 * pick(16)), 5'd0, 3'b010, rd, op_load);
        default: image[i] = store_word(12'(-2048 + 4 * pick(16)), rs2, 5'd0);
      endcase
    end
    // Register dump followed by a jump to itself
    for (int r = 1; r < 32; r++) begin
      image[body_len + r - 1] = store_word(12'(-1024 + 4 * r), 5'(r), 5'd0);
    end
    image[body_len + 31] = jump_word(21'd0, 5'd0);
  endtask

  task automatic run_model();
    logic [31:0] model_mem [mem_words];
    logic [31:0] xr [32];
    logic [31:0] pc;
    logic [31:0] next_pc;
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] addr;
    logic [31:0] result;
    logic        writes;
    int          steps;
    for (int w = 0; w < mem_words; w++) begin
      model_mem[w] = image[w];
    end
    for (int r = 0; r < 32; r++) begin
      xr[r] = '0;
    end
    pc    = '0;
    steps = 0;
    while (pc != halt_addr && steps < total_instr) begin
      ins     = model_mem[pc[11:2]];
      a       = xr[ins[19:15]];
      b       = xr[ins[24:20]];
      next_pc = pc + 32'd4;
      result  = '0;
      addr    = '0;
      writes  = 1'b1;
      case (ins[6:0])
        op_reg:   result = alu_result(ins[14:12], ins[30], a, b);
        op_imm:   result = alu_result(ins[14:12], ins[30] && ins[14:12] == f3_srl_sra, a,
                                      i_imm(ins));
        op_lui:   result = u_imm(ins);
        op_auipc: result = pc + u_imm(ins);
        op_jal: begin
          result  = pc + 32'd4;
          next_pc = pc + j_imm(ins);
        end
        op_jalr: begin
          result  = pc + 32'd4;
          next_pc = (a + i_imm(ins)) & ~32'd1;
        end
        op_branch: begin
          writes = 1'b0;
          if (branch_taken(ins[14:12], a, b)) begin
            next_pc = pc + b_imm(ins);
          end
        end
        op_load: begin
          addr   = a + i_imm(ins);
          result = model_mem[addr[11:2]];
        end
        op_store: begin
          writes = 1'b0;
          addr   = a + s_imm(ins);
          model_mem[addr[11:2]] = b;
          exp_addr.push_back(addr);
          exp_data.push_back(b);
        end
        default: writes = 1'b0;
      endcase
      if (writes && ins[11:7] != 5'd0) begin
        xr[ins[11:7]] = result;
      end
      pc = next_pc;
      steps++;
    end
  endtask

  // Store checker on the falling edge
  always @(negedge clock) begin
    if (!reset) begin
      if (mem_wr_en) begin
        assert (!prev_wr_en) else begin
          write_errors++;
          $display("mem_wr_en held high for more than one cycle at %0t", $time);
        end
        assert (wr_count < exp_addr.size()) else begin
          write_errors++;
          $display("Unexpected extra memory write at %0t to address %h", $time, mem_addr);
        end
        if (wr_count < exp_addr.size()) begin
          assert (mem_addr == exp_addr[wr_count]) else begin
            write_errors++;
            $display("MISMATCH at %0t: mem_addr got %h expected %h", $time, mem_addr,
                     exp_addr[wr_count]);
          end
          assert (wr_data == exp_data[wr_count]) else begin
            write_errors++;
            $display("MISMATCH at %0t: wr_data got %h expected %h", $time, wr_data,
                     exp_data[wr_count]);
          end
        end
        wr_count++;
      end
      prev_wr_en <= mem_wr_en;
    end
  end

  initial begin
    build_program();
    run_model();
    for (int w = 0; w < mem_words; w++) begin
      mem[w] <= image[w];
    end
    repeat (3) begin
      @(posedge clock);
    end
    reset <= 1'b0;
    @(negedge clock);
    assert (mem_addr == 32'd0) else begin
      errors++;
      $display("MISMATCH at %0t: mem_addr got %h expected %h", $time, mem_addr, 32'd0);
    end
    assert (!mem_wr_en) else begin
      errors++;
      $display("mem_wr_en is high in the first cycle after reset");
    end
    // Run until the core fetches the final self jump
    while (mem_addr != halt_addr && cycles < cycle_limit) begin
      @(negedge clock);
      cycles++;
    end
    assert (cycles < cycle_limit) else begin
      errors++;
      $display("Timeout: halt loop not reached within %0d cycles", cycle_limit);
    end
    repeat (10) begin
      @(posedge clock);
    end
    assert (wr_count == exp_addr.size()) else begin
      errors++;
      $display("Wrong number of memory writes: saw %0d, expected %0d", wr_count,
               exp_addr.size());
    end
    $display("Write errors: %0d, other errors: %0d, writes: %0d of %0d, cycles: %0d",
             write_errors, errors, wr_count, exp_addr.size(), cycles);
    if (errors == 0 && write_errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire
